// ==== ex_cfg.svh ====
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// number of alu lanes, power of two
`define EX_LANES 4

// lane index width, log2 of EX_LANES
`define EX_LANE_W 2

// datapath width
`define EX_XLEN 32

// one-hot alu_op width
`define EX_OP_W 17

`endif

// ==== ex_pkg.sv ====
package ex_pkg;

  // rv32i instruction word, decoded as r, i or b format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
  } rv_instr_u;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // one-hot alu_op bit positions
  localparam int ALU_ADD  = 0;
  localparam int ALU_SUB  = 1;
  localparam int ALU_SLT  = 2;
  localparam int ALU_SLTU = 3;
  localparam int ALU_AND  = 4;
  localparam int ALU_OR   = 5;
  localparam int ALU_XOR  = 6;
  localparam int ALU_SLL  = 7;
  localparam int ALU_SRL  = 8;
  localparam int ALU_SRA  = 9;
  localparam int ALU_LUI  = 10;
  localparam int ALU_BNE  = 11;
  localparam int ALU_BEQ  = 12;
  localparam int ALU_BGE  = 13;
  localparam int ALU_BGEU = 14;
  localparam int ALU_BLT  = 15;
  localparam int ALU_BLTU = 16;

endpackage

// ==== ex_alu.sv ====
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_alu (
  input  logic                double_cal,
  input  logic [`EX_OP_W-1:0] alu_op,
  input  logic [`EX_XLEN-1:0] alu_src1,
  input  logic [`EX_XLEN-1:0] alu_src2,
  input  logic [`EX_XLEN-1:0] alu_src3,
  input  logic [`EX_XLEN-1:0] alu_src4,
  output logic [`EX_XLEN-1:0] alu_result1,
  output logic                alu_result2
);
  import ex_pkg::*;

  localparam int SH_W = $clog2(`EX_XLEN);
  localparam int MSB  = `EX_XLEN - 1;

  logic op_add, op_sub, op_slt, op_sltu;
  logic op_and, op_or, op_xor;
  logic op_sll, op_srl, op_sra, op_lui;
  logic op_bne, op_beq, op_bge, op_bgeu, op_blt, op_bltu;
  logic use_sub;

  logic [`EX_XLEN-1:0]   adder_b;
  logic                  adder_cin;
  logic [`EX_XLEN-1:0]   adder_result;
  logic                  adder_cout;
  logic [`EX_XLEN-1:0]   cmp_result;
  logic                  cmp_cout;

  logic [`EX_XLEN-1:0]   slt_result;
  logic [`EX_XLEN-1:0]   sltu_result;
  logic [`EX_XLEN-1:0]   sll_result;
  logic [2*`EX_XLEN-1:0] sr_wide;
  logic [`EX_XLEN-1:0]   sr_result;
  logic                  beq_result;
  logic                  blt_result;
  logic                  bltu_result;

  assign op_add  = alu_op[ALU_ADD];
  assign op_sub  = alu_op[ALU_SUB];
  assign op_slt  = alu_op[ALU_SLT];
  assign op_sltu = alu_op[ALU_SLTU];
  assign op_and  = alu_op[ALU_AND];
  assign op_or   = alu_op[ALU_OR];
  assign op_xor  = alu_op[ALU_XOR];
  assign op_sll  = alu_op[ALU_SLL];
  assign op_srl  = alu_op[ALU_SRL];
  assign op_sra  = alu_op[ALU_SRA];
  assign op_lui  = alu_op[ALU_LUI];
  assign op_bne  = alu_op[ALU_BNE];
  assign op_beq  = alu_op[ALU_BEQ];
  assign op_bge  = alu_op[ALU_BGE];
  assign op_bgeu = alu_op[ALU_BGEU];
  assign op_blt  = alu_op[ALU_BLT];
  assign op_bltu = alu_op[ALU_BLTU];

  // main adder shared by add/sub/slt/sltu and the branch target
  assign use_sub   = op_sub | op_slt | op_sltu;
  assign adder_b   = use_sub ? ~alu_src2 : alu_src2;
  assign adder_cin = use_sub;
  assign {adder_cout, adder_result} = alu_src1 + adder_b + {{`EX_XLEN{1'b0}}, adder_cin};

  // second subtractor computes src3 - src4 for branch compare
  assign {cmp_cout, cmp_result} = alu_src3 + {1'b0, ~alu_src4} + {{`EX_XLEN{1'b0}}, 1'b1};

  assign slt_result  = {{(`EX_XLEN-1){1'b0}},
                        (alu_src1[MSB] & ~alu_src2[MSB])
                        | ((alu_src1[MSB] ~^ alu_src2[MSB]) & adder_result[MSB])};
  assign sltu_result = {{(`EX_XLEN-1){1'b0}}, ~adder_cout};

  assign blt_result  = (alu_src3[MSB] & ~alu_src4[MSB])
                     | ((alu_src3[MSB] ~^ alu_src4[MSB]) & cmp_result[MSB]);
  assign bltu_result = ~cmp_cout;
  assign beq_result  = (alu_src3 == alu_src4);

  assign sll_result = alu_src1 << alu_src2[SH_W-1:0];

  // upper half carries the sign fill for sra
  assign sr_wide   = {{`EX_XLEN{op_sra & alu_src1[MSB]}}, alu_src1} >> alu_src2[SH_W-1:0];
  assign sr_result = sr_wide[`EX_XLEN-1:0];

  assign alu_result1 = ({`EX_XLEN{op_add | op_sub | double_cal}} & adder_result)
                     | ({`EX_XLEN{op_slt}}                       & slt_result)
                     | ({`EX_XLEN{op_sltu}}                      & sltu_result)
                     | ({`EX_XLEN{op_and}}                       & (alu_src1 & alu_src2))
                     | ({`EX_XLEN{op_or}}                        & (alu_src1 | alu_src2))
                     | ({`EX_XLEN{op_xor}}                       & (alu_src1 ^ alu_src2))
                     | ({`EX_XLEN{op_lui}}                       & alu_src2)
                     | ({`EX_XLEN{op_sll}}                       & sll_result)
                     | ({`EX_XLEN{op_srl | op_sra}}              & sr_result);

  // non-branch ops report 1 here
  assign alu_result2 = ~double_cal ? 1'b1         :
                       op_beq      ? beq_result   :
                       op_blt      ? blt_result   :
                       op_bltu     ? bltu_result  :
                       op_bge      ? ~blt_result  :
                       op_bgeu     ? ~bltu_result :
                       op_bne      ? ~beq_result  :
                       1'b0;

endmodule

// ==== ex_dispatch.sv ====
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_dispatch (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue,
  input  ex_pkg::rv_instr_u     instr,
  input  logic [`EX_XLEN-1:0]   rs1_val,
  input  logic [`EX_XLEN-1:0]   rs2_val,
  input  logic [`EX_XLEN-1:0]   pc,
  output logic                  illegal,
  output logic [`EX_LANES-1:0]  lane_go,
  output logic [`EX_OP_W-1:0]   lane_op,
  output logic                  lane_dual,
  output logic [`EX_XLEN-1:0]   lane_src1,
  output logic [`EX_XLEN-1:0]   lane_src2,
  output logic [`EX_XLEN-1:0]   lane_src3,
  output logic [`EX_XLEN-1:0]   lane_src4,
  output logic [4:0]            lane_rd,
  output logic                  lane_is_br
);
  import ex_pkg::*;

  logic [6:0]             funct7;
  logic [2:0]             funct3;
  logic [`EX_XLEN-1:0]    imm_i;
  logic [`EX_XLEN-1:0]    imm_b;
  logic [`EX_XLEN-1:0]    imm_u;
  logic [`EX_OP_W-1:0]    op_d;
  logic [`EX_XLEN-1:0]    src1_d;
  logic [`EX_XLEN-1:0]    src2_d;
  logic                   legal;
  logic                   is_br;
  logic                   accept;
  logic [`EX_LANE_W-1:0]  ptr;
  logic [`EX_LANES-1:0]   go_d;

  // funct3 to one-hot for OP and OP-IMM, alt selects sub/sra
  function automatic logic [`EX_OP_W-1:0] arith_op(input logic [2:0] f3, input logic alt);
    logic [`EX_OP_W-1:0] op;
    op = '0;
    case (f3)
      3'b000: op[alt ? ALU_SUB : ALU_ADD] = 1'b1;
      3'b001: op[ALU_SLL] = 1'b1;
      3'b010: op[ALU_SLT] = 1'b1;
      3'b011: op[ALU_SLTU] = 1'b1;
      3'b100: op[ALU_XOR] = 1'b1;
      3'b101: op[alt ? ALU_SRA : ALU_SRL] = 1'b1;
      3'b110: op[ALU_OR] = 1'b1;
      default: op[ALU_AND] = 1'b1;
    endcase
    return op;
  endfunction

  assign funct7 = instr.r.funct7;
  assign funct3 = instr.r.funct3;
  assign imm_i  = {{(`EX_XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
  assign imm_b  = {{(`EX_XLEN-12){instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
                   instr.b.imm4_1, 1'b0};
  assign imm_u  = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'b0};

  always_comb begin
    op_d   = '0;
    legal  = 1'b0;
    is_br  = 1'b0;
    src1_d = rs1_val;
    src2_d = rs2_val;
    case (instr.r.opcode)
      OPC_OP: begin
        legal = (funct7 == 7'h00)
              || ((funct7 == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
        op_d  = arith_op(funct3, funct7[5]);
      end
      OPC_OP_IMM: begin
        // shift immediates carry funct7 in imm12[11:5]
        legal  = (funct3 == 3'b001) ? (funct7 == 7'h00) :
                 (funct3 == 3'b101) ? ((funct7 == 7'h00) || (funct7 == 7'h20)) : 1'b1;
        op_d   = arith_op(funct3, (funct3 == 3'b101) && funct7[5]);
        src2_d = imm_i;
      end
      OPC_LUI: begin
        legal         = 1'b1;
        op_d[ALU_LUI] = 1'b1;
        src2_d        = imm_u;
      end
      OPC_BRANCH: begin
        legal  = (funct3 != 3'b010) && (funct3 != 3'b011);
        is_br  = 1'b1;
        src1_d = pc;
        src2_d = imm_b;
        case (funct3)
          3'b000:  op_d[ALU_BEQ] = 1'b1;
          3'b001:  op_d[ALU_BNE] = 1'b1;
          3'b100:  op_d[ALU_BLT] = 1'b1;
          3'b101:  op_d[ALU_BGE] = 1'b1;
          3'b110:  op_d[ALU_BLTU] = 1'b1;
          default: op_d[ALU_BGEU] = 1'b1;
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

  assign accept = issue && legal;

  always_comb begin
    go_d      = '0;
    go_d[ptr] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lane_go <= '0;
      illegal <= 1'b0;
      ptr     <= '0;
    end else begin
      lane_go <= accept ? go_d : '0;
      illegal <= issue && !legal;
      if (accept) begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // shared lane buses
  always_ff @(posedge clk) begin
    if (accept) begin
      lane_op    <= op_d;
      lane_dual  <= is_br;
      lane_is_br <= is_br;
      lane_src1  <= src1_d;
      lane_src2  <= src2_d;
      lane_src3  <= rs1_val;
      lane_src4  <= rs2_val;
      lane_rd    <= instr.r.rd;
    end
  end

  // a lane strobe only follows a legal issue, one lane at a time
  a_go_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    (|lane_go) |-> $onehot(lane_go) && $past(issue) && !illegal);

endmodule

// ==== ex_lane.sv ====
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_lane (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                go,
  input  logic [`EX_OP_W-1:0] op,
  input  logic                dual,
  input  logic [`EX_XLEN-1:0] src1,
  input  logic [`EX_XLEN-1:0] src2,
  input  logic [`EX_XLEN-1:0] src3,
  input  logic [`EX_XLEN-1:0] src4,
  input  logic [4:0]          rd,
  input  logic                is_br,
  output logic                done,
  output logic [`EX_XLEN-1:0] result1,
  output logic                result2,
  output logic [4:0]          rd_q,
  output logic                is_br_q
);

  logic [`EX_XLEN-1:0] alu_res1;
  logic                alu_res2;

  ex_alu u_alu (
    .double_cal  (dual),
    .alu_op      (op),
    .alu_src1    (src1),
    .alu_src2    (src2),
    .alu_src3    (src3),
    .alu_src4    (src4),
    .alu_result1 (alu_res1),
    .alu_result2 (alu_res2)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else begin
      done <= go;
    end
  end

  // shared buses are only ours while go is high
  always_ff @(posedge clk) begin
    if (go) begin
      result1 <= alu_res1;
      result2 <= alu_res2;
      rd_q    <= rd;
      is_br_q <= is_br;
    end
  end

  a_op_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    go |-> $onehot(op) && (dual == is_br));

endmodule

// ==== ex_retire.sv ====
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_retire (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [`EX_LANES-1:0]           done,
  input  logic [`EX_LANES*`EX_XLEN-1:0]  result1,
  input  logic [`EX_LANES-1:0]           result2,
  input  logic [`EX_LANES*5-1:0]         rd,
  input  logic [`EX_LANES-1:0]           is_br,
  output logic                           ret_valid,
  output logic                           ret_wen,
  output logic [4:0]                     ret_rd,
  output logic [`EX_XLEN-1:0]            ret_wdata,
  output logic                           br_valid,
  output logic                           br_taken,
  output logic [`EX_XLEN-1:0]            br_target
);

  logic [`EX_LANE_W-1:0] ptr;
  logic [`EX_LANES-1:0]  ptr_mask;
  logic                  hit;
  logic [`EX_XLEN-1:0]   sel_res1;
  logic [4:0]            sel_rd;

  always_comb begin
    ptr_mask      = '0;
    ptr_mask[ptr] = 1'b1;
  end

  assign hit      = done[ptr];
  assign sel_res1 = result1[ptr*`EX_XLEN +: `EX_XLEN];
  assign sel_rd   = rd[ptr*5 +: 5];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr       <= '0;
      ret_valid <= 1'b0;
      ret_wen   <= 1'b0;
      br_valid  <= 1'b0;
    end else begin
      ret_valid <= hit && !is_br[ptr];
      ret_wen   <= hit && !is_br[ptr] && (sel_rd != 5'd0);
      br_valid  <= hit && is_br[ptr];
      if (hit) begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hit) begin
      ret_rd    <= sel_rd;
      ret_wdata <= sel_res1;
      br_taken  <= result2[ptr];
      br_target <= sel_res1;
    end
  end

  // lanes finish in the same order dispatch filled them
  a_in_order: assert property (@(posedge clk) disable iff (!rst_n)
    (done & ~ptr_mask) == '0);

endmodule

// ==== ex_cluster.sv ====
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_cluster (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                issue,
  input  ex_pkg::rv_instr_u   instr,
  input  logic [`EX_XLEN-1:0] rs1_val,
  input  logic [`EX_XLEN-1:0] rs2_val,
  input  logic [`EX_XLEN-1:0] pc,
  output logic                illegal,
  output logic                ret_valid,
  output logic                ret_wen,
  output logic [4:0]          ret_rd,
  output logic [`EX_XLEN-1:0] ret_wdata,
  output logic                br_valid,
  output logic                br_taken,
  output logic [`EX_XLEN-1:0] br_target
);

  logic [`EX_LANES-1:0]          lane_go;
  logic [`EX_OP_W-1:0]           lane_op;
  logic                          lane_dual;
  logic [`EX_XLEN-1:0]           lane_src1;
  logic [`EX_XLEN-1:0]           lane_src2;
  logic [`EX_XLEN-1:0]           lane_src3;
  logic [`EX_XLEN-1:0]           lane_src4;
  logic [4:0]                    lane_rd;
  logic                          lane_is_br;

  logic [`EX_LANES-1:0]          lane_done;
  logic [`EX_LANES*`EX_XLEN-1:0] lane_res1;
  logic [`EX_LANES-1:0]          lane_res2;
  logic [`EX_LANES*5-1:0]        lane_rd_q;
  logic [`EX_LANES-1:0]          lane_br_q;

  ex_dispatch u_dispatch (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue      (issue),
    .instr      (instr),
    .rs1_val    (rs1_val),
    .rs2_val    (rs2_val),
    .pc         (pc),
    .illegal    (illegal),
    .lane_go    (lane_go),
    .lane_op    (lane_op),
    .lane_dual  (lane_dual),
    .lane_src1  (lane_src1),
    .lane_src2  (lane_src2),
    .lane_src3  (lane_src3),
    .lane_src4  (lane_src4),
    .lane_rd    (lane_rd),
    .lane_is_br (lane_is_br)
  );

  for (genvar i = 0; i < `EX_LANES; i++) begin : g_lane
    ex_lane u_lane (
      .clk     (clk),
      .rst_n   (rst_n),
      .go      (lane_go[i]),
      .op      (lane_op),
      .dual    (lane_dual),
      .src1    (lane_src1),
      .src2    (lane_src2),
      .src3    (lane_src3),
      .src4    (lane_src4),
      .rd      (lane_rd),
      .is_br   (lane_is_br),
      .done    (lane_done[i]),
      .result1 (lane_res1[i*`EX_XLEN +: `EX_XLEN]),
      .result2 (lane_res2[i]),
      .rd_q    (lane_rd_q[i*5 +: 5]),
      .is_br_q (lane_br_q[i])
    );
  end

  ex_retire u_retire (
    .clk       (clk),
    .rst_n     (rst_n),
    .done      (lane_done),
    .result1   (lane_res1),
    .result2   (lane_res2),
    .rd        (lane_rd_q),
    .is_br     (lane_br_q),
    .ret_valid (ret_valid),
    .ret_wen   (ret_wen),
    .ret_rd    (ret_rd),
    .ret_wdata (ret_wdata),
    .br_valid  (br_valid),
    .br_taken  (br_taken),
    .br_target (br_target)
  );

endmodule

// ==== tb_ex_cluster.sv ====
`timescale 1ns/10ps
`include "ex_cfg.svh"

module tb_ex_cluster;
  import ex_pkg::*;

  localparam int K_RET = 0;
  localparam int K_BR  = 1;
  localparam int K_ILL = 2;

  logic                clk;
  logic                rst_n;
  logic                issue;
  rv_instr_u           instr;
  logic [`EX_XLEN-1:0] rs1_val;
  logic [`EX_XLEN-1:0] rs2_val;
  logic [`EX_XLEN-1:0] pc;
  logic                illegal;
  logic                ret_valid;
  logic                ret_wen;
  logic [4:0]          ret_rd;
  logic [`EX_XLEN-1:0] ret_wdata;
  logic                br_valid;
  logic                br_taken;
  logic [`EX_XLEN-1:0] br_target;

  // stimulus table
  string       tbl_name[$];
  logic [31:0] tbl_word[$];
  logic [31:0] tbl_rs1[$];
  logic [31:0] tbl_rs2[$];
  logic [31:0] tbl_pc[$];
  logic [1:0]  tbl_rnd[$];
  bit          tbl_sync[$];

  // expected results in issue order with illegal pulses kept apart
  int          exp_idx[$];
  int          exp_cyc[$];
  bit          exp_br[$];
  logic [31:0] exp_val[$];
  logic [4:0]  exp_rd[$];
  logic        exp_wen[$];
  logic        exp_taken[$];
  int          ill_idx[$];
  int          ill_cyc[$];

  int          cycle = 0;
  int          errors = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  bit          mon_on = 1'b0;
  int unsigned lcg_state = 98631;

  ex_cluster u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue     (issue),
    .instr     (instr),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .pc        (pc),
    .illegal   (illegal),
    .ret_valid (ret_valid),
    .ret_wen   (ret_wen),
    .ret_rd    (ret_rd),
    .ret_wdata (ret_wdata),
    .br_valid  (br_valid),
    .br_taken  (br_taken),
    .br_target (br_target)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd);
    rv_instr_u w;
    w          = '0;
    w.r.funct7 = f7;
    w.r.rs2    = 5'd2;
    w.r.rs1    = 5'd1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = OPC_OP;
    return w;
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    rv_instr_u w;
    w          = '0;
    w.i.imm12  = imm;
    w.i.rs1    = 5'd1;
    w.i.funct3 = f3;
    w.i.rd     = rd;
    w.i.opcode = opc;
    return w;
  endfunction

  // offset is the 13-bit signed branch displacement
  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [2:0] f3);
    rv_instr_u w;
    w           = '0;
    w.b.imm12   = off[12];
    w.b.imm10_5 = off[10:5];
    w.b.rs2     = 5'd2;
    w.b.rs1     = 5'd1;
    w.b.funct3  = f3;
    w.b.imm4_1  = off[4:1];
    w.b.imm11   = off[11];
    w.b.opcode  = OPC_BRANCH;
    return w;
  endfunction

  function automatic logic [31:0] rv_arith(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] x, input logic [31:0] y);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? x - y : x + y;
      3'd1: r = x << y[4:0];
      3'd2: r = {31'd0, $signed(x) < $signed(y)};
      3'd3: r = {31'd0, x < y};
      3'd4: r = x ^ y;
      3'd5: begin
        if (alt) begin
          r = $signed(x) >>> y[4:0];
        end else begin
          r = x >> y[4:0];
        end
      end
      3'd6: r = x | y;
      default: r = x & y;
    endcase
    return r;
  endfunction

  // rv32i reference decoded straight from the raw word bits
  task automatic model(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b,
                       input logic [31:0] p, output int kind, output logic [31:0] val,
                       output logic taken);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    f3    = w[14:12];
    f7    = w[31:25];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    kind  = K_ILL;
    val   = '0;
    taken = 1'b0;
    case (w[6:0])
      7'h33: begin
        if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
          kind = K_RET;
          val  = rv_arith(f3, f7[5], a, b);
        end
      end
      7'h13: begin
        if (!(f3 == 3'd1 && f7 != 7'h00)
            && !(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)) begin
          kind = K_RET;
          val  = rv_arith(f3, (f3 == 3'd5) && f7[5], a, imm_i);
        end
      end
      7'h37: begin
        kind = K_RET;
        val  = {w[31:12], 12'h000};
      end
      7'h63: begin
        if (f3 != 3'd2 && f3 != 3'd3) begin
          kind = K_BR;
          val  = p + imm_b;
          case (f3)
            3'd0: taken = (a == b);
            3'd1: taken = (a != b);
            3'd4: taken = ($signed(a) < $signed(b));
            3'd5: taken = ($signed(a) >= $signed(b));
            3'd6: taken = (a < b);
            default: taken = (a >= b);
          endcase
        end
      end
      default: kind = K_ILL;
    endcase
  endtask

  task automatic add_entry(input string name, input logic [31:0] w, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] p, input logic [1:0] rnd,
                           input bit sync);
    tbl_name.push_back(name);
    tbl_word.push_back(w);
    tbl_rs1.push_back(a);
    tbl_rs2.push_back(b);
    tbl_pc.push_back(p);
    tbl_rnd.push_back(rnd);
    tbl_sync.push_back(sync);
  endtask

  task automatic build_table();
    string       br_name[6] = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};
    logic [2:0]  br_f3[6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [12:0] br_off[3] = '{13'd16, 13'h1000, 13'd4094};
    logic [31:0] br_a[3] = '{32'd5, 32'hfffffff0, 32'd3};
    logic [31:0] br_b[3] = '{32'd5, 32'd3, 32'hfffffff0};
    logic [31:0] w;
    add_entry("add_ovf", enc_r(7'h00, 3'd0, 5'd5), 32'h7fffffff, 32'd1, 0, 2'b00, 1);
    add_entry("add_x0", enc_r(7'h00, 3'd0, 5'd0), 32'd3, 32'd4, 0, 2'b00, 1);
    add_entry("sub", enc_r(7'h20, 3'd0, 5'd6), 32'd0, 32'd1, 0, 2'b00, 1);
    add_entry("slt_neg", enc_r(7'h00, 3'd2, 5'd7), 32'h80000000, 32'd1, 0, 2'b00, 1);
    add_entry("slt_pos", enc_r(7'h00, 3'd2, 5'd7), 32'd5, 32'h80000000, 0, 2'b00, 1);
    add_entry("sltu", enc_r(7'h00, 3'd3, 5'd8), 32'd1, 32'h80000000, 0, 2'b00, 1);
    add_entry("and", enc_r(7'h00, 3'd7, 5'd9), 0, 0, 0, 2'b11, 1);
    add_entry("or", enc_r(7'h00, 3'd6, 5'd10), 0, 0, 0, 2'b11, 1);
    add_entry("xor", enc_r(7'h00, 3'd4, 5'd11), 0, 0, 0, 2'b11, 1);
    // shift amounts only use the low five bits
    add_entry("sll_31", enc_r(7'h00, 3'd1, 5'd12), 32'd1, 32'h3f, 0, 2'b00, 1);
    add_entry("srl_31", enc_r(7'h00, 3'd5, 5'd13), 32'h80000000, 32'd31, 0, 2'b00, 1);
    add_entry("sra_31", enc_r(7'h20, 3'd5, 5'd14), 32'h80000000, 32'd31, 0, 2'b00, 1);
    add_entry("addi_m1", enc_i(12'hfff, 3'd0, 5'd15, OPC_OP_IMM), 0, 0, 0, 2'b00, 1);
    add_entry("slti", enc_i(12'hfff, 3'd2, 5'd16, OPC_OP_IMM), 32'h80000000, 0, 0, 2'b00, 1);
    add_entry("sltiu", enc_i(12'hfff, 3'd3, 5'd17, OPC_OP_IMM), 32'd5, 0, 0, 2'b00, 1);
    add_entry("andi", enc_i(12'h7ff, 3'd7, 5'd18, OPC_OP_IMM), 0, 0, 0, 2'b01, 1);
    add_entry("ori", enc_i(12'h800, 3'd6, 5'd19, OPC_OP_IMM), 0, 0, 0, 2'b01, 1);
    add_entry("xori", enc_i(12'hfff, 3'd4, 5'd0, OPC_OP_IMM), 0, 0, 0, 2'b01, 1);
    add_entry("slli_31", enc_i(12'h01f, 3'd1, 5'd20, OPC_OP_IMM), 32'd3, 0, 0, 2'b00, 1);
    add_entry("srli_31", enc_i(12'h01f, 3'd5, 5'd21, OPC_OP_IMM), 32'hc0000000, 0, 0, 2'b00, 1);
    add_entry("srai_31", enc_i(12'h41f, 3'd5, 5'd22, OPC_OP_IMM), 32'hc0000000, 0, 0, 2'b00, 1);
    add_entry("lui", {20'hfffff, 5'd23, OPC_LUI}, 0, 0, 0, 2'b00, 1);
    // equal, signed-less and unsigned-less pairs per condition
    for (int c = 0; c < 6; c++) begin
      for (int k = 0; k < 3; k++) begin
        add_entry($sformatf("%s_%0d", br_name[c], k), enc_b(br_off[k], br_f3[c]),
                  br_a[k], br_b[k], 32'h1000 + 32'h40 * (3 * c + k), 2'b00, 1);
      end
    end
    for (int k = 0; k < 12; k++) begin
      if (k == 5) begin
        w = enc_b(13'd64, 3'd4);
      end else begin
        w = enc_r((k == 8) ? 7'h20 : 7'h00, 3'(k), 5'(k + 1));
      end
      add_entry($sformatf("burst_%0d", k), w, 0, 0, 32'h2000, 2'b11, k == 11);
    end
    add_entry("ill_nbr_a", enc_i(12'd5, 3'd0, 5'd3, OPC_OP_IMM), 32'd7, 0, 0, 2'b00, 0);
    add_entry("ill_load", enc_i(12'd0, 3'd2, 5'd4, 7'h03), 0, 0, 0, 2'b00, 0);
    add_entry("ill_nbr_b", enc_r(7'h00, 3'd4, 5'd24), 0, 0, 0, 2'b11, 1);
    add_entry("ill_mul", enc_r(7'h01, 3'd0, 5'd6), 32'd2, 32'd3, 0, 2'b00, 1);
    add_entry("ill_br_f3", enc_b(13'd16, 3'd2), 32'd1, 32'd1, 32'h40, 2'b00, 1);
    add_entry("ill_slli", enc_i(12'h403, 3'd1, 5'd7, OPC_OP_IMM), 32'd1, 0, 0, 2'b00, 1);
  endtask

  task automatic report_value(input string sig, input string tname, input logic [31:0] expv,
                              input logic [31:0] got, inout int errs);
    $display("ERROR %s: test %s expected %0h got %0h", sig, tname, expv, got);
    errs++;
  endtask

  task automatic finish_test(input string tname, input int errs);
    $display("test %-12s %s", tname, (errs == 0) ? "ok" : "FAILED");
    if (errs == 0) begin
      n_pass++;
    end else begin
      n_fail++;
    end
    errors += errs;
  endtask

  task automatic check_result();
    int   idx;
    int   cyc;
    int   errs;
    bit   br;
    string tname;
    if (exp_idx.size() == 0) begin
      $display("unexpected result pulse at cycle %0d with nothing in flight", cycle);
      errors++;
    end else begin
      idx   = exp_idx.pop_front();
      cyc   = exp_cyc.pop_front();
      br    = exp_br.pop_front();
      tname = tbl_name[idx];
      errs  = 0;
      if (cycle - cyc != 3) begin
        $display("test %s retired %0d cycles after issue instead of 3", tname, cycle - cyc);
        errs++;
      end
      if (ret_valid !== !br) report_value("ret_valid", tname, !br, ret_valid, errs);
      if (br_valid !== br) report_value("br_valid", tname, br, br_valid, errs);
      if (br) begin
        if (br_taken !== exp_taken[0]) report_value("br_taken", tname, exp_taken[0], br_taken, errs);
        if (br_target !== exp_val[0]) report_value("br_target", tname, exp_val[0], br_target, errs);
      end else begin
        if (ret_wen !== exp_wen[0]) report_value("ret_wen", tname, exp_wen[0], ret_wen, errs);
        if (ret_rd !== exp_rd[0]) report_value("ret_rd", tname, exp_rd[0], ret_rd, errs);
        if (ret_wdata !== exp_val[0]) report_value("ret_wdata", tname, exp_val[0], ret_wdata, errs);
      end
      void'(exp_val.pop_front());
      void'(exp_rd.pop_front());
      void'(exp_wen.pop_front());
      void'(exp_taken.pop_front());
      finish_test(tname, errs);
    end
  endtask

  task automatic check_illegal();
    int idx;
    int cyc;
    int errs;
    if (ill_idx.size() == 0) begin
      $display("unexpected illegal pulse at cycle %0d", cycle);
      errors++;
    end else begin
      idx  = ill_idx.pop_front();
      cyc  = ill_cyc.pop_front();
      errs = 0;
      if (cycle - cyc != 1) begin
        $display("test %s flagged illegal %0d cycles after issue instead of 1",
                 tbl_name[idx], cycle - cyc);
        errs++;
      end
      finish_test(tbl_name[idx], errs);
    end
  endtask

  task automatic check_quiet(inout int errs);
    if (ret_valid !== 1'b0) report_value("ret_valid", "reset", 0, ret_valid, errs);
    if (br_valid !== 1'b0) report_value("br_valid", "reset", 0, br_valid, errs);
    if (illegal !== 1'b0) report_value("illegal", "reset", 0, illegal, errs);
  endtask

  task automatic wait_drain(input int limit);
    int t;
    t = 0;
    while ((exp_idx.size() != 0 || ill_idx.size() != 0) && t < limit) begin
      @(posedge clk);
      t++;
    end
    if (exp_idx.size() != 0 || ill_idx.size() != 0) begin
      $display("timeout: %0d results and %0d illegal pulses never appeared",
               exp_idx.size(), ill_idx.size());
      n_fail += exp_idx.size() + ill_idx.size();
      errors++;
      exp_idx.delete();
      exp_cyc.delete();
      exp_br.delete();
      exp_val.delete();
      exp_rd.delete();
      exp_wen.delete();
      exp_taken.delete();
      ill_idx.delete();
      ill_cyc.delete();
    end
  endtask

  // outputs settle after the rising edge and are sampled on the falling one
  always @(negedge clk) begin
    if (mon_on) begin
      if (ret_valid !== 1'b0 || br_valid !== 1'b0) begin
        check_result();
      end
      if (illegal !== 1'b0) begin
        check_illegal();
      end
    end
  end

  initial begin
    int          rerrs;
    int          kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic        taken;
    rst_n   = 1'b0;
    issue   = 1'b0;
    instr   = '0;
    rs1_val = '0;
    rs2_val = '0;
    pc      = '0;
    rerrs   = 0;
    build_table();
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #1;
      check_quiet(rerrs);
    end
    rst_n = 1'b1;
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      check_quiet(rerrs);
    end
    finish_test("reset", rerrs);
    mon_on = 1'b1;

    for (int n = 0; n < tbl_word.size(); n++) begin
      a = tbl_rnd[n][0] ? lcg_next() : tbl_rs1[n];
      b = tbl_rnd[n][1] ? lcg_next() : tbl_rs2[n];
      model(tbl_word[n], a, b, tbl_pc[n], kind, val, taken);
      @(posedge clk);
      #1;
      issue   = 1'b1;
      instr   = tbl_word[n];
      rs1_val = a;
      rs2_val = b;
      pc      = tbl_pc[n];
      if (kind == K_ILL) begin
        ill_idx.push_back(n);
        ill_cyc.push_back(cycle);
      end else begin
        exp_idx.push_back(n);
        exp_cyc.push_back(cycle);
        exp_br.push_back(kind == K_BR);
        exp_val.push_back(val);
        exp_rd.push_back(tbl_word[n][11:7]);
        exp_wen.push_back((kind == K_RET) && (tbl_word[n][11:7] != 5'd0));
        exp_taken.push_back(taken);
      end
      if (tbl_sync[n]) begin
        @(posedge clk);
        #1;
        issue = 1'b0;
        wait_drain(20);
      end
    end
    @(posedge clk);
    #1;
    issue = 1'b0;
    wait_drain(40);
    // a few idle cycles so stray pulses still get caught
    repeat (6) @(posedge clk);

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             n_pass + n_fail, n_pass, n_fail, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+.
ex_pkg.sv
ex_alu.sv
ex_dispatch.sv
ex_lane.sv
ex_retire.sv
ex_cluster.sv
tb_ex_cluster.sv
